// ==== design/lbc_pkg.sv ====
package lbc_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------

  localparam int LBC_QDEPTH = 4;
  localparam int LBC_LINE_WORDS = 4;

  localparam int LBC_PTR_W = $clog2(LBC_QDEPTH);
  localparam int LBC_CNT_W = $clog2(LBC_QDEPTH + 1);
  localparam int LBC_BEAT_W = $clog2(LBC_LINE_WORDS);

  // Requester id carried with every request and every returned word.
  localparam logic LBC_ID_INSTR = 1'b0;
  localparam logic LBC_ID_DATA = 1'b1;

  // ------------------------------
  // Request and return types
  // ------------------------------

  // Bus command as driven on lbc_cmd.
  typedef struct packed {
    logic rw;
    logic line;
    logic uc;
  } lbc_cmd_t;

  // One queued request.
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    lbc_cmd_t    cmd;
    logic        id;
  } lbc_req_t;

  // One read word on its way back to the processor.
  typedef struct packed {
    logic [31:0] data;
    logic        id;
    logic        last;
  } lbc_ret_t;

endpackage

// ==== design/lbc_cbus.sv ====
module lbc_cbus import lbc_pkg::*; (
  input  logic        busclk,
  input  logic        rst,
  input  logic        cbus_dreq,
  input  logic [31:0] cbus_daddr,
  input  logic        cbus_drw,
  input  logic        cbus_dline,
  input  logic        cbus_duc,
  input  logic [31:0] cbus_do,
  input  logic        cbus_ireq,
  input  logic [31:0] cbus_iaddr,
  input  logic        cbus_iuc,
  input  logic        wbdisable,
  input  logic        queue_full,
  input  logic        ret_valid,
  input  lbc_ret_t    ret,
  input  logic        wr_done,
  output logic        push,
  output lbc_req_t    push_req,
  output logic        cbus_halt,
  output logic        cbus_sival,
  output logic [31:0] cbus_sidata,
  output logic        cbus_sdval,
  output logic [31:0] cbus_sddata
);

  logic                 ipend;
  logic [31:0]          iaddr_q;
  logic                 iuc_q;
  logic                 take_i;
  logic [1:0]           rd_new;
  logic [1:0]           rd_cnt;
  logic                 ret_last_r;
  logic                 wr_strobe;
  logic [LBC_CNT_W-1:0] wr_cnt;
  logic [LBC_CNT_W-1:0] wr_cnt_nxt;
  logic                 wb_wait;

  // ------------------------------
  // Request capture
  // ------------------------------

  // A fetch that arrives together with a data request waits one slot in ipend.
  assign take_i = ipend ? !queue_full : (cbus_ireq && !cbus_dreq);

  always_ff @(posedge busclk) begin
    if (rst) begin
      ipend <= 1'b0;
    end else if (ipend) begin
      ipend <= queue_full;
    end else begin
      ipend <= cbus_ireq && cbus_dreq;
    end
  end

  always_ff @(posedge busclk) begin
    if (cbus_ireq) begin
      iaddr_q <= cbus_iaddr;
      iuc_q <= cbus_iuc;
    end
  end

  always_comb begin
    push = 1'b0;
    push_req = '0;
    if (cbus_dreq) begin
      push = 1'b1;
      push_req.addr = cbus_daddr;
      push_req.data = cbus_do;
      push_req.cmd.rw = cbus_drw;
      push_req.cmd.line = cbus_dline;
      push_req.cmd.uc = cbus_duc;
      push_req.id = LBC_ID_DATA;
    end else if (take_i) begin
      push = 1'b1;
      push_req.addr = ipend ? iaddr_q : cbus_iaddr;
      push_req.cmd.uc = ipend ? iuc_q : cbus_iuc;
      push_req.id = LBC_ID_INSTR;
    end
  end

  // ------------------------------
  // Halt tracking
  // ------------------------------

  // At most one data read and one fetch can be outstanding together.
  assign rd_new = {1'b0, cbus_dreq && !cbus_drw} + {1'b0, cbus_ireq};

  assign wr_strobe = cbus_dreq && cbus_drw;
  assign wr_cnt_nxt = wr_cnt + LBC_CNT_W'(wr_strobe) - LBC_CNT_W'(wr_done);

  always_ff @(posedge busclk) begin
    if (rst) begin
      rd_cnt <= 2'd0;
      wr_cnt <= '0;
      wb_wait <= 1'b0;
    end else begin
      rd_cnt <= rd_cnt + rd_new - {1'b0, ret_last_r};
      wr_cnt <= wr_cnt_nxt;
      // Unbuffered writes hold the processor until every write in flight is done.
      wb_wait <= (wb_wait || (wr_strobe && wbdisable)) && (wr_cnt_nxt != '0);
    end
  end

  assign cbus_halt = (rd_cnt != 2'd0) || wb_wait || ipend || queue_full;

  // ------------------------------
  // Read return
  // ------------------------------

  always_ff @(posedge busclk) begin
    if (rst) begin
      cbus_sival <= 1'b0;
      cbus_sdval <= 1'b0;
      ret_last_r <= 1'b0;
    end else begin
      cbus_sival <= ret_valid && (ret.id == LBC_ID_INSTR);
      cbus_sdval <= ret_valid && (ret.id == LBC_ID_DATA);
      ret_last_r <= ret_valid && ret.last;
    end
  end

  always_ff @(posedge busclk) begin
    if (ret_valid && (ret.id == LBC_ID_INSTR)) begin
      cbus_sidata <= ret.data;
    end
    if (ret_valid && (ret.id == LBC_ID_DATA)) begin
      cbus_sddata <= ret.data;
    end
  end

endmodule

// ==== design/lbc_queue.sv ====
module lbc_queue import lbc_pkg::*; (
  input  logic     busclk,
  input  logic     rst,
  input  logic     push,
  input  lbc_req_t push_req,
  input  logic     pop,
  output lbc_req_t head,
  output logic     head_valid,
  output logic     queue_full,
  output logic     cbus_swbempty
);

  lbc_req_t             mem [LBC_QDEPTH];
  logic [LBC_PTR_W-1:0] wr_ptr;
  logic [LBC_PTR_W-1:0] rd_ptr;
  logic [LBC_CNT_W-1:0] count;
  logic [LBC_CNT_W-1:0] wr_count;
  logic                 do_push;
  logic                 do_pop;

  function automatic logic [LBC_PTR_W-1:0] ptr_inc(input logic [LBC_PTR_W-1:0] p);
    if (p == LBC_PTR_W'(LBC_QDEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign queue_full = (count == LBC_CNT_W'(LBC_QDEPTH));
  assign head_valid = (count != '0);
  assign head = mem[rd_ptr];

  assign do_push = push && !queue_full;
  assign do_pop = pop && head_valid;

  // ------------------------------
  // Storage and pointers
  // ------------------------------

  always_ff @(posedge busclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_req;
    end
  end

  always_ff @(posedge busclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count <= count + LBC_CNT_W'(do_push) - LBC_CNT_W'(do_pop);
    end
  end

  // ------------------------------
  // Write buffer status
  // ------------------------------

  // A write leaves the count only when its bus transaction has completed.
  always_ff @(posedge busclk) begin
    if (rst) begin
      wr_count <= '0;
    end else begin
      wr_count <= wr_count + LBC_CNT_W'(do_push && push_req.cmd.rw)
                  - LBC_CNT_W'(do_pop && head.cmd.rw);
    end
  end

  assign cbus_swbempty = (wr_count == '0);

endmodule

// ==== design/lbc_lbus.sv ====
module lbc_lbus import lbc_pkg::*; (
  input  logic        busclk,
  input  logic        rst,
  input  lbc_req_t    head,
  input  logic        head_valid,
  input  logic        lbus_gnt,
  input  logic        lbus_trdy,
  input  logic        lbus_abort,
  input  logic [31:0] lbus_data,
  output logic        pop,
  output logic        ret_valid,
  output lbc_ret_t    ret,
  output logic        wr_done,
  output logic        lbc_req,
  output logic        lbc_frame,
  output logic        lbc_irdy,
  output logic [31:0] lbc_addr,
  output logic [31:0] lbc_data,
  output lbc_cmd_t    lbc_cmd,
  output logic        lbc_id,
  output logic        lbc_doe
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_REQ,
    ST_ADDR,
    ST_DATA,
    ST_RETRY
  } state_t;

  state_t                state;
  state_t                state_nxt;
  lbc_req_t              cur;
  logic [LBC_BEAT_W-1:0] beat;
  logic [LBC_BEAT_W-1:0] done_cnt;
  logic                  last_beat;
  logic                  abort_hit;
  logic                  phase_done;

  // ------------------------------
  // Phase decode
  // ------------------------------

  assign last_beat = !cur.cmd.line || (beat == LBC_BEAT_W'(LBC_LINE_WORDS - 1));
  assign abort_hit = lbus_abort && (lbc_frame || lbc_irdy);
  assign phase_done = (state == ST_DATA) && lbus_trdy && !abort_hit;

  assign lbc_req = (state == ST_REQ);
  assign lbc_frame = (state == ST_ADDR) || ((state == ST_DATA) && !last_beat);
  assign lbc_irdy = (state == ST_DATA);
  assign lbc_doe = lbc_irdy && cur.cmd.rw;

  assign lbc_addr = cur.addr;
  assign lbc_data = cur.data;
  assign lbc_cmd = cur.cmd;
  assign lbc_id = cur.id;

  assign pop = phase_done && last_beat;
  assign wr_done = pop && cur.cmd.rw;

  // After a retry, words that already went back to the processor are skipped.
  assign ret_valid = phase_done && !cur.cmd.rw && (beat == done_cnt);
  assign ret.data = lbus_data;
  assign ret.id = cur.id;
  assign ret.last = last_beat;

  // ------------------------------
  // Sequencer
  // ------------------------------

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (head_valid) begin
          state_nxt = ST_REQ;
        end
      end
      ST_REQ: begin
        if (lbus_gnt) begin
          state_nxt = ST_ADDR;
        end
      end
      ST_ADDR: begin
        state_nxt = abort_hit ? ST_RETRY : ST_DATA;
      end
      ST_DATA: begin
        if (abort_hit) begin
          state_nxt = ST_RETRY;
        end else if (pop) begin
          state_nxt = ST_IDLE;
        end
      end
      ST_RETRY: begin
        state_nxt = ST_REQ;
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge busclk) begin
    if (rst) begin
      state <= ST_IDLE;
      beat <= '0;
      done_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (state == ST_ADDR) begin
        beat <= '0;
      end else if (phase_done) begin
        beat <= beat + 1'b1;
      end
      if (pop) begin
        done_cnt <= '0;
      end else if (ret_valid) begin
        done_cnt <= done_cnt + 1'b1;
      end
    end
  end

  // The head request is copied once and held until it is popped.
  always_ff @(posedge busclk) begin
    if ((state == ST_IDLE) && head_valid) begin
      cur <= head;
    end
  end

endmodule

// ==== design/lbc_lbi.sv ====
module lbc_lbi import lbc_pkg::*; (
  input  logic        busclk,
  input  logic        rst,
  input  logic        cbus_dreq,
  input  logic [31:0] cbus_daddr,
  input  logic        cbus_drw,
  input  logic        cbus_dline,
  input  logic        cbus_duc,
  input  logic [31:0] cbus_do,
  input  logic        cbus_ireq,
  input  logic [31:0] cbus_iaddr,
  input  logic        cbus_iuc,
  input  logic        wbdisable,
  output logic        cbus_halt,
  output logic        cbus_swbempty,
  output logic        cbus_sival,
  output logic [31:0] cbus_sidata,
  output logic        cbus_sdval,
  output logic [31:0] cbus_sddata,
  input  logic        lbus_gnt,
  input  logic        lbus_trdy,
  input  logic        lbus_abort,
  input  logic [31:0] lbus_data,
  output logic        lbc_req,
  output logic        lbc_frame,
  output logic        lbc_irdy,
  output logic [31:0] lbc_addr,
  output logic [31:0] lbc_data,
  output lbc_cmd_t    lbc_cmd,
  output logic        lbc_id,
  output logic        lbc_doe
);

  logic     push;
  lbc_req_t push_req;
  logic     queue_full;
  lbc_req_t head;
  logic     head_valid;
  logic     pop;
  logic     ret_valid;
  lbc_ret_t ret;
  logic     wr_done;

  // ------------------------------
  // Processor side
  // ------------------------------

  lbc_cbus cbus (
    .busclk      (busclk),
    .rst         (rst),
    .cbus_dreq   (cbus_dreq),
    .cbus_daddr  (cbus_daddr),
    .cbus_drw    (cbus_drw),
    .cbus_dline  (cbus_dline),
    .cbus_duc    (cbus_duc),
    .cbus_do     (cbus_do),
    .cbus_ireq   (cbus_ireq),
    .cbus_iaddr  (cbus_iaddr),
    .cbus_iuc    (cbus_iuc),
    .wbdisable   (wbdisable),
    .queue_full  (queue_full),
    .ret_valid   (ret_valid),
    .ret         (ret),
    .wr_done     (wr_done),
    .push        (push),
    .push_req    (push_req),
    .cbus_halt   (cbus_halt),
    .cbus_sival  (cbus_sival),
    .cbus_sidata (cbus_sidata),
    .cbus_sdval  (cbus_sdval),
    .cbus_sddata (cbus_sddata)
  );

  lbc_queue queue (
    .busclk        (busclk),
    .rst           (rst),
    .push          (push),
    .push_req      (push_req),
    .pop           (pop),
    .head          (head),
    .head_valid    (head_valid),
    .queue_full    (queue_full),
    .cbus_swbempty (cbus_swbempty)
  );

  // ------------------------------
  // Bus side
  // ------------------------------

  lbc_lbus lbus (
    .busclk     (busclk),
    .rst        (rst),
    .head       (head),
    .head_valid (head_valid),
    .lbus_gnt   (lbus_gnt),
    .lbus_trdy  (lbus_trdy),
    .lbus_abort (lbus_abort),
    .lbus_data  (lbus_data),
    .pop        (pop),
    .ret_valid  (ret_valid),
    .ret        (ret),
    .wr_done    (wr_done),
    .lbc_req    (lbc_req),
    .lbc_frame  (lbc_frame),
    .lbc_irdy   (lbc_irdy),
    .lbc_addr   (lbc_addr),
    .lbc_data   (lbc_data),
    .lbc_cmd    (lbc_cmd),
    .lbc_id     (lbc_id),
    .lbc_doe    (lbc_doe)
  );

endmodule

// ==== tb/lbc_target_model.sv ====
module lbc_target_model import lbc_pkg::*; (
  input  logic        busclk,
  input  logic        rst,
  input  logic        abort_en,
  input  logic        lbc_req,
  input  logic        lbc_frame,
  input  logic        lbc_irdy,
  input  logic [31:0] lbc_addr,
  input  logic [31:0] lbc_data,
  input  lbc_cmd_t    lbc_cmd,
  input  logic        lbc_doe,
  output logic        lbus_gnt,
  output logic        lbus_trdy,
  output logic        lbus_abort,
  output logic [31:0] lbus_data,
  output int          wr_completed,
  output int          bus_errors
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] lfsr_state = 32'hae35_cf2f;
  logic [31:0] mem [logic [31:0]];
  logic [31:0] base;
  int          gnt_wait;
  int          data_wait;
  int          beat;
  int          abort_beat;
  bit          abort_now;
  bit          is_write;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return addr ^ 32'h5a5a_0000;
  endfunction

  // Drives one data phase cycle, which aborts, waits or presents the word.
  task automatic drive_beat();
    if (abort_now && (beat == abort_beat)) begin
      lbus_abort <= 1'b1;
      lbus_trdy <= 1'b0;
    end else if (data_wait == 0) begin
      lbus_trdy <= 1'b1;
      lbus_data <= read_word(base + 32'(4 * beat));
    end else begin
      lbus_trdy <= 1'b0;
      data_wait--;
    end
  endtask

  initial begin
    lbus_gnt = 1'b0;
    lbus_trdy = 1'b0;
    lbus_abort = 1'b0;
    lbus_data = '0;
  end

  always @(posedge busclk) begin
    if (rst) begin
      lbus_gnt <= 1'b0;
      lbus_trdy <= 1'b0;
      lbus_abort <= 1'b0;
      lbus_data <= '0;
      wr_completed = 0;
      bus_errors = 0;
      gnt_wait = 0;
    end else begin
      lbus_gnt <= 1'b0;
      if (lbc_req && !lbus_gnt) begin
        if (gnt_wait == 0) begin
          lbus_gnt <= 1'b1;
          gnt_wait = int'(rand_bits(2));
        end else begin
          gnt_wait--;
        end
      end
      if (lbc_frame && !lbc_irdy) begin
        // Uncached accesses are those with address bit 8 or bit 16 set.
        assert (lbc_cmd.uc == (lbc_addr[8] | lbc_addr[16])) else begin
          $display("[ERROR] bus uc: expected %h, actual %h",
                   lbc_addr[8] | lbc_addr[16], lbc_cmd.uc);
          bus_errors++;
        end
        base = lbc_addr;
        beat = 0;
        is_write = lbc_cmd.rw;
        abort_now = abort_en && (rand_bits(2) == 32'd0);
        abort_beat = lbc_cmd.line ? int'(rand_bits(2)) : 0;
        data_wait = int'(rand_bits(2) % 3);
        drive_beat();
      end else if (lbc_irdy) begin
        assert (lbc_doe == is_write) else begin
          $display("[ERROR] bus doe: expected %b, actual %b", is_write, lbc_doe);
          bus_errors++;
        end
        if (lbus_abort) begin
          lbus_abort <= 1'b0;
          lbus_trdy <= 1'b0;
        end else if (lbus_trdy) begin
          if (lbc_cmd.rw) begin
            mem[base + 32'(4 * beat)] = lbc_data;
            if (!lbc_frame) begin
              wr_completed++;
            end
          end
          if (!lbc_frame) begin
            lbus_trdy <= 1'b0;
          end else begin
            beat++;
            data_wait = int'(rand_bits(2) % 3);
            drive_beat();
          end
        end else begin
          drive_beat();
        end
      end
    end
  end

endmodule

// ==== tb/tb_lbc.sv ====
module tb_lbc import lbc_pkg::*; ;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 6 * 200 * 60;

  logic        busclk;
  logic        rst;
  logic        cbus_dreq;
  logic [31:0] cbus_daddr;
  logic        cbus_drw;
  logic        cbus_dline;
  logic        cbus_duc;
  logic [31:0] cbus_do;
  logic        cbus_ireq;
  logic [31:0] cbus_iaddr;
  logic        cbus_iuc;
  logic        wbdisable;
  logic        cbus_halt;
  logic        cbus_swbempty;
  logic        cbus_sival;
  logic [31:0] cbus_sidata;
  logic        cbus_sdval;
  logic [31:0] cbus_sddata;
  logic        lbus_gnt;
  logic        lbus_trdy;
  logic        lbus_abort;
  logic [31:0] lbus_data;
  logic        lbc_req;
  logic        lbc_frame;
  logic        lbc_irdy;
  logic [31:0] lbc_addr;
  logic [31:0] lbc_data;
  lbc_cmd_t    lbc_cmd;
  logic        lbc_id;
  logic        lbc_doe;
  logic        abort_en;
  int          target_writes;
  int          target_errors;

  logic [31:0] lfsr_state = 32'hae35_cf2f;
  logic [31:0] model_mem [logic [31:0]];
  logic [31:0] dexp [$];
  logic [31:0] iexp [$];
  logic        id_exp [$];
  string       test_name;
  int          checks;
  int          errors;
  int          checks_at_start;
  int          errors_at_start;
  int          wr_strobes;
  int          cycles;

  lbc_lbi i_lbc_lbi (.*);

  lbc_target_model i_target (
    .busclk       (busclk),
    .rst          (rst),
    .abort_en     (abort_en),
    .lbc_req      (lbc_req),
    .lbc_frame    (lbc_frame),
    .lbc_irdy     (lbc_irdy),
    .lbc_addr     (lbc_addr),
    .lbc_data     (lbc_data),
    .lbc_cmd      (lbc_cmd),
    .lbc_doe      (lbc_doe),
    .lbus_gnt     (lbus_gnt),
    .lbus_trdy    (lbus_trdy),
    .lbus_abort   (lbus_abort),
    .lbus_data    (lbus_data),
    .wr_completed (target_writes),
    .bus_errors   (target_errors)
  );

  initial begin
    busclk = 1'b0;
    forever #10 busclk = ~busclk;
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] word_addr();
    logic [31:0] r;
    r = rand_bits(8);
    return {22'h0, r[7:0], 2'b00};
  endfunction

  function automatic logic [31:0] line_addr();
    logic [31:0] r;
    r = rand_bits(6);
    return {22'h0, r[5:0], 4'h0};
  endfunction

  // This region is never written and is always uncached.
  function automatic logic [31:0] far_addr();
    logic [31:0] r;
    r = rand_bits(8);
    return {16'h0001, 6'h0, r[7:0], 2'b00};
  endfunction

  function automatic logic uc_for(input logic [31:0] addr);
    return addr[8] | addr[16];
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    if (model_mem.exists(addr)) begin
      return model_mem[addr];
    end
    return addr ^ 32'h5a5a_0000;
  endfunction

  task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    assert (expected === actual) else begin
      $display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      $display("Test %s went wrong: %s", test_name, what);
      errors++;
    end
  endtask

  task automatic wait_ready();
    do @(posedge busclk); while (cbus_halt);
  endtask

  // Gives one request slot and follows it until the processor may go on.
  task automatic send(input bit dreq, input bit rw, input bit line, input bit ireq,
                      input logic [31:0] daddr, input logic [31:0] ddata,
                      input logic [31:0] iaddr, input bit wb);
    wait_ready();
    cbus_dreq <= dreq;
    cbus_drw <= rw;
    cbus_dline <= line;
    cbus_daddr <= daddr;
    cbus_duc <= uc_for(daddr);
    cbus_do <= ddata;
    cbus_ireq <= ireq;
    cbus_iaddr <= iaddr;
    cbus_iuc <= uc_for(iaddr);
    wbdisable <= wb;
    if (dreq && rw) begin
      model_mem[daddr] = ddata;
      wr_strobes++;
    end else if (dreq) begin
      for (int k = 0; k < (line ? LBC_LINE_WORDS : 1); k++) begin
        dexp.push_back(model_read(daddr + 32'(4 * k)));
      end
    end
    if (ireq) begin
      iexp.push_back(model_read(iaddr));
    end
    if (dreq) begin
      id_exp.push_back(LBC_ID_DATA);
    end
    if (ireq) begin
      id_exp.push_back(LBC_ID_INSTR);
    end
    @(posedge busclk);
    cbus_dreq <= 1'b0;
    cbus_ireq <= 1'b0;
    @(posedge busclk);
    if ((dreq && !rw) || ireq || (rw && wb)) begin
      check_true(cbus_halt, "cbus_halt did not rise after the request");
      while (cbus_halt) @(posedge busclk);
      check_true(dexp.size() == 0 && iexp.size() == 0,
                 "cbus_halt fell before all read words returned");
      if (rw && wb) begin
        check_value(wr_strobes, target_writes);
      end
    end else begin
      check_true(!cbus_swbempty, "cbus_swbempty high while a posted write waits");
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    checks_at_start = checks;
    errors_at_start = errors;
  endtask

  task automatic finish_test(input int num);
    do @(posedge busclk);
    while (cbus_halt || lbc_req || lbc_frame || lbc_irdy || target_writes < wr_strobes ||
           dexp.size() != 0 || iexp.size() != 0);
    check_value(wr_strobes, target_writes);
    check_true(cbus_swbempty, "cbus_swbempty low after the queue drained");
    $display("Test %0d %s: %0d checks, %0d errors", num, test_name,
             checks - checks_at_start, errors - errors_at_start);
  endtask

  // ------------------------------
  // Return path and timeout
  // ------------------------------

  always @(posedge busclk) begin
    if (!rst) begin
      if (cbus_sdval) begin
        if (dexp.size() == 0) begin
          check_true(1'b0, "unexpected pulse on cbus_sdval");
        end else begin
          check_value(dexp.pop_front(), cbus_sddata);
        end
      end
      if (cbus_sival) begin
        check_true(dexp.size() == 0, "instruction word returned before the data word");
        if (iexp.size() == 0) begin
          check_true(1'b0, "unexpected pulse on cbus_sival");
        end else begin
          check_value(iexp.pop_front(), cbus_sidata);
        end
      end
    end
  end

  // A bus transaction carries the id of the oldest request that has not completed.
  always @(posedge busclk) begin
    if (!rst && lbc_frame && !lbc_irdy) begin
      if (id_exp.size() == 0) begin
        check_true(1'b0, "bus transaction started without a pending request");
      end else begin
        check_value(32'(id_exp[0]), 32'(lbc_id));
      end
    end
    if (!rst && lbc_irdy && !lbc_frame && lbus_trdy && !lbus_abort &&
        id_exp.size() != 0) begin
      id_exp.delete(0);
    end
  end

  always @(posedge busclk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // ------------------------------
  // Tests
  // ------------------------------

  initial begin
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] sel;
    rst = 1'b1;
    cbus_dreq = 1'b0;
    cbus_daddr = '0;
    cbus_drw = 1'b0;
    cbus_dline = 1'b0;
    cbus_duc = 1'b0;
    cbus_do = '0;
    cbus_ireq = 1'b0;
    cbus_iaddr = '0;
    cbus_iuc = 1'b0;
    wbdisable = 1'b0;
    abort_en = 1'b0;
    checks = 0;
    errors = 0;
    wr_strobes = 0;
    cycles = 0;
    repeat (16) @(posedge busclk);
    rst <= 1'b0;

    start_test("write then read");
    for (int i = 0; i < 100; i++) begin
      a = word_addr();
      d = rand_bits(32);
      send(1'b1, 1'b1, 1'b0, 1'b0, a, d, '0, 1'b0);
      send(1'b1, 1'b0, 1'b0, 1'b0, a, '0, '0, 1'b0);
    end
    finish_test(1);

    start_test("uncached reads");
    for (int i = 0; i < 200; i++) begin
      send(1'b1, 1'b0, 1'b0, 1'b0, far_addr(), '0, '0, 1'b0);
    end
    finish_test(2);

    start_test("line reads");
    for (int i = 0; i < 200; i++) begin
      if (rand_bits(1) == 32'd1) begin
        send(1'b1, 1'b1, 1'b0, 1'b0, word_addr(), rand_bits(32), '0, 1'b0);
      end else begin
        send(1'b1, 1'b0, 1'b1, 1'b0, line_addr(), '0, '0, 1'b0);
      end
    end
    finish_test(3);

    start_test("fetch mix");
    for (int i = 0; i < 200; i++) begin
      sel = rand_bits(2);
      case (sel)
        32'd0: send(1'b1, 1'b0, 1'b0, 1'b1, word_addr(), '0, word_addr(), 1'b0);
        32'd1: send(1'b0, 1'b0, 1'b0, 1'b1, '0, '0, word_addr(), 1'b0);
        32'd2: send(1'b1, 1'b1, 1'b0, 1'b0, word_addr(), rand_bits(32), '0, 1'b0);
        default: send(1'b1, 1'b0, 1'b0, 1'b0, word_addr(), '0, '0, 1'b0);
      endcase
    end
    finish_test(4);

    start_test("aborts");
    abort_en <= 1'b1;
    for (int i = 0; i < 200; i++) begin
      sel = rand_bits(2);
      case (sel)
        32'd0: send(1'b1, 1'b1, 1'b0, 1'b0, word_addr(), rand_bits(32), '0, 1'b0);
        32'd1: send(1'b1, 1'b0, 1'b0, 1'b0, word_addr(), '0, '0, 1'b0);
        32'd2: send(1'b1, 1'b0, 1'b1, 1'b0, line_addr(), '0, '0, 1'b0);
        default: send(1'b1, 1'b0, 1'b0, 1'b1, word_addr(), '0, word_addr(), 1'b0);
      endcase
    end
    finish_test(5);
    abort_en <= 1'b0;

    start_test("write buffer disable");
    for (int i = 0; i < 100; i++) begin
      send(1'b1, 1'b1, 1'b0, 1'b0, word_addr(), rand_bits(32), '0, 1'b1);
    end
    for (int i = 0; i < 100; i++) begin
      send(1'b1, 1'b1, 1'b0, 1'b0, word_addr(), rand_bits(32), '0, 1'b0);
    end
    finish_test(6);

    errors += target_errors;
    $display("Tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
design/lbc_pkg.sv
design/lbc_cbus.sv
design/lbc_queue.sv
design/lbc_lbus.sv
design/lbc_lbi.sv
tb/lbc_target_model.sv
tb/tb_lbc.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_lbc
FILELIST = verilog.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
